/* verilog/odd_pipe_pkg.sv */
package odd_pipe_pkg;

    // datapath widths
    localparam int QUAD_WIDTH = 128;
    localparam int ADDR_WIDTH = 7;
    localparam int PC_WIDTH   = 32;

    // element widths used by gather and the branch tests
    localparam int BYTE     = 8;
    localparam int HALFWORD = 16;
    localparam int WORD     = 32;

    // number of forwarding stages behind execute
    localparam int PIPE_DEPTH = 7;

    localparam int UNIT_WIDTH = 3;
    localparam int LAT_WIDTH  = 4;

    // unit ids as carried in the forward entry
    localparam logic [UNIT_WIDTH-1:0] UNIT_PERMUTE = 3'd5;
    localparam logic [UNIT_WIDTH-1:0] UNIT_BRANCH  = 3'd7;

    // stage at which a result may first be forwarded
    localparam logic [LAT_WIDTH-1:0] LAT_PERMUTE = 4'd4;
    localparam logic [LAT_WIDTH-1:0] LAT_BRANCH  = 4'd1;

    typedef enum logic [4:0] {
        OP_NOP     = 5'd0,
        // quadword shift left, bits and bytes
        OP_SHLQBI  = 5'd1,
        OP_SHLQBII = 5'd2,
        OP_SHLQBY  = 5'd3,
        OP_SHLQBYI = 5'd4,
        // quadword rotate, bits and bytes
        OP_ROTQBI  = 5'd5,
        OP_ROTQBII = 5'd6,
        OP_ROTQBY  = 5'd7,
        OP_ROTQBYI = 5'd8,
        // gather lsb of bytes, halfwords, words
        OP_GBB     = 5'd9,
        OP_GBH     = 5'd10,
        OP_GB      = 5'd11,
        // unconditional branches
        OP_BR      = 5'd12,
        OP_BRA     = 5'd13,
        OP_BRSL    = 5'd14,
        OP_BRASL   = 5'd15,
        // conditional branches on rb
        OP_BRNZ    = 5'd16,
        OP_BRZ     = 5'd17,
        OP_BRHNZ   = 5'd18,
        OP_BRHZ    = 5'd19
    } opcode_t;

    // one issued instruction with its operands already read
    typedef struct packed {
        opcode_t                 op;
        logic [0:QUAD_WIDTH-1]   ra;
        logic [0:QUAD_WIDTH-1]   rb;
        logic [0:ADDR_WIDTH-1]   rt_addr;
        logic [6:0]              i7;
        logic [15:0]             i16;
        logic [0:PC_WIDTH-1]     pc;
    } issue_t;

    // one slot of the forwarding chain, 144 bits
    typedef struct packed {
        logic                    valid;
        logic [UNIT_WIDTH-1:0]   unit_id;
        logic [0:QUAD_WIDTH-1]   value;
        logic                    write_en;
        logic [0:ADDR_WIDTH-1]   rt_addr;
        logic [LAT_WIDTH-1:0]    latency;
    } fw_entry_t;

endpackage

/* verilog/operand_latch.sv */
`timescale 1ns/100ps

module operand_latch (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  odd_pipe_pkg::issue_t  issue,
    input  logic                  flush,
    output odd_pipe_pkg::issue_t  latched,
    output logic                  latched_valid
);

    import odd_pipe_pkg::*;

    logic load_bubble;

    // an idle cycle, a reset or a taken branch all leave a bubble
    assign load_bubble = reset || flush || !issue_valid;

    // operands and immediates follow the input every cycle
    always_ff @(posedge clock)
    begin
        latched.ra      <= issue.ra;
        latched.rb      <= issue.rb;
        latched.rt_addr <= issue.rt_addr;
        latched.i7      <= issue.i7;
        latched.i16     <= issue.i16;
        latched.pc      <= issue.pc;
    end

    // opcode and valid decide whether the slot does anything
    always_ff @(posedge clock)
    begin
        if (load_bubble)
        begin
            latched.op    <= OP_NOP;
            latched_valid <= 1'b0;
        end
        else
        begin
            latched.op    <= issue.op;
            latched_valid <= 1'b1;
        end
    end

endmodule

/* verilog/permute_unit.sv */
`timescale 1ns/100ps

module permute_unit (
    input  odd_pipe_pkg::opcode_t                 op,
    input  logic [0:odd_pipe_pkg::QUAD_WIDTH-1]   ra,
    input  logic [0:odd_pipe_pkg::QUAD_WIDTH-1]   rb,
    input  logic [6:0]                            i7,
    output logic [0:odd_pipe_pkg::QUAD_WIDTH-1]   result,
    output logic                                  is_permute
);

    import odd_pipe_pkg::*;

    logic [7:0]              amount;
    logic                    rotate;
    logic                    gather;
    logic [0:2*QUAD_WIDTH-1] shifted;
    logic [0:WORD-1]         gathered;

    // lsb of every element, element 0 lands highest in the low bits of word 0
    function automatic logic [0:WORD-1] gather_lsb(
        input logic [0:QUAD_WIDTH-1] value,
        input int                    width
    );
        logic [0:WORD-1] bits;
        int              count;
        bits  = '0;
        count = QUAD_WIDTH / width;
        for (int j = 0; j < WORD; j++)
        begin
            if (j < count)
                bits[WORD - count + j] = value[j*width + width - 1];
        end
        return bits;
    endfunction

    // count decode, byte forms are scaled to a bit amount
    always_comb
    begin
        amount     = 8'd0;
        rotate     = 1'b0;
        gather     = 1'b0;
        gathered   = '0;
        is_permute = 1'b1;
        case (op)
            OP_SHLQBI:  amount = {5'd0, rb[29:31]};
            OP_SHLQBII: amount = {5'd0, i7[2:0]};
            OP_SHLQBY:  amount = 8'(rb[27:31] * BYTE);
            OP_SHLQBYI: amount = 8'(i7[4:0] * BYTE);
            OP_ROTQBI:
            begin
                amount = {5'd0, rb[29:31]};
                rotate = 1'b1;
            end
            OP_ROTQBII:
            begin
                amount = {5'd0, i7[2:0]};
                rotate = 1'b1;
            end
            OP_ROTQBY:
            begin
                amount = 8'(rb[28:31] * BYTE);
                rotate = 1'b1;
            end
            OP_ROTQBYI:
            begin
                amount = 8'(i7[3:0] * BYTE);
                rotate = 1'b1;
            end
            OP_GBB:
            begin
                gather   = 1'b1;
                gathered = gather_lsb(ra, BYTE);
            end
            OP_GBH:
            begin
                gather   = 1'b1;
                gathered = gather_lsb(ra, HALFWORD);
            end
            OP_GB:
            begin
                gather   = 1'b1;
                gathered = gather_lsb(ra, WORD);
            end
            default: is_permute = 1'b0;
        endcase
    end

    // the lower half refills from ra for rotates and with zeros for shifts
    assign shifted = {ra, (rotate ? ra : {QUAD_WIDTH{1'b0}})} << amount;

    assign result = gather ? {gathered, {(QUAD_WIDTH-WORD){1'b0}}}
                           : shifted[0:QUAD_WIDTH-1];

endmodule

/* verilog/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit (
    input  odd_pipe_pkg::opcode_t                 op,
    input  logic [0:odd_pipe_pkg::QUAD_WIDTH-1]   rb,
    input  logic [15:0]                           i16,
    input  logic [0:odd_pipe_pkg::PC_WIDTH-1]     pc,
    input  logic                                  valid,
    output logic                                  taken,
    output logic [0:odd_pipe_pkg::PC_WIDTH-1]     target,
    output logic [0:odd_pipe_pkg::QUAD_WIDTH-1]   link,
    output logic                                  is_branch,
    output logic                                  writes_link
);

    import odd_pipe_pkg::*;

    logic [0:PC_WIDTH-1] offset;
    logic                absolute;
    logic                condition;
    logic                word_zero;
    logic                half_zero;

    // word offset, sign extended
    assign offset = {{(PC_WIDTH-18){i16[15]}}, i16, 2'b00};

    assign word_zero = (rb[0:WORD-1] == '0);
    assign half_zero = (rb[WORD-HALFWORD:WORD-1] == '0);

    always_comb
    begin
        is_branch   = 1'b1;
        absolute    = 1'b0;
        writes_link = 1'b0;
        condition   = 1'b1;
        case (op)
            OP_BR:    ;
            OP_BRA:   absolute = 1'b1;
            OP_BRSL:  writes_link = 1'b1;
            OP_BRASL:
            begin
                absolute    = 1'b1;
                writes_link = 1'b1;
            end
            OP_BRNZ:  condition = !word_zero;
            OP_BRZ:   condition = word_zero;
            OP_BRHNZ: condition = !half_zero;
            OP_BRHZ:  condition = half_zero;
            default:
            begin
                is_branch = 1'b0;
                condition = 1'b0;
            end
        endcase
    end

    assign taken  = valid && is_branch && condition;
    assign target = absolute ? offset : pc + offset;

    // return address in word 0 only
    assign link = {pc + PC_WIDTH'(4), {(QUAD_WIDTH-PC_WIDTH){1'b0}}};

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
    input  odd_pipe_pkg::issue_t               latched,
    input  logic                               latched_valid,
    output odd_pipe_pkg::fw_entry_t            entry,
    output logic                               branch_taken,
    output logic [0:odd_pipe_pkg::PC_WIDTH-1]  pc_target
);

    import odd_pipe_pkg::*;

    logic [0:QUAD_WIDTH-1] permute_result;
    logic                  is_permute;
    logic [0:QUAD_WIDTH-1] link;
    logic                  is_branch;
    logic                  writes_link;

    permute_unit permute_unit_inst (
        .op         (latched.op),
        .ra         (latched.ra),
        .rb         (latched.rb),
        .i7         (latched.i7),
        .result     (permute_result),
        .is_permute (is_permute)
    );

    branch_unit branch_unit_inst (
        .op          (latched.op),
        .rb          (latched.rb),
        .i16         (latched.i16),
        .pc          (latched.pc),
        .valid       (latched_valid),
        .taken       (branch_taken),
        .target      (pc_target),
        .link        (link),
        .is_branch   (is_branch),
        .writes_link (writes_link)
    );

    // nop and bubbles decode to neither unit and leave an empty slot
    always_comb
    begin
        entry.valid    = latched_valid && (is_permute || is_branch);
        entry.rt_addr  = latched.rt_addr;
        entry.write_en = is_permute || writes_link;
        if (is_branch)
        begin
            entry.unit_id = UNIT_BRANCH;
            entry.latency = LAT_BRANCH;
            entry.value   = link;
        end
        else if (is_permute)
        begin
            entry.unit_id = UNIT_PERMUTE;
            entry.latency = LAT_PERMUTE;
            entry.value   = permute_result;
        end
        else
        begin
            entry.unit_id = '0;
            entry.latency = '0;
            entry.value   = '0;
        end
    end

endmodule

/* verilog/forward_stage.sv */
`timescale 1ns/100ps

module forward_stage #(
    parameter int STAGE = 1
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  odd_pipe_pkg::fw_entry_t               entry_in,
    output odd_pipe_pkg::fw_entry_t               entry_out,
    input  logic [0:odd_pipe_pkg::ADDR_WIDTH-1]   query_addr,
    output logic                                  hit
);

    import odd_pipe_pkg::*;

    always_ff @(posedge clock)
    begin
        entry_out <= entry_in;
        if (reset)
        begin
            entry_out.valid    <= 1'b0;
            entry_out.write_en <= 1'b0;
        end
    end

    // result is only usable once the unit has had its full latency
    assign hit = entry_out.valid && entry_out.write_en
                 && (entry_out.rt_addr == query_addr)
                 && (LAT_WIDTH'(STAGE) >= entry_out.latency);

endmodule

/* verilog/forward_select.sv */
`timescale 1ns/100ps

module forward_select (
    input  odd_pipe_pkg::fw_entry_t               stage_entry [odd_pipe_pkg::PIPE_DEPTH],
    input  logic [odd_pipe_pkg::PIPE_DEPTH-1:0]   stage_hit,
    output logic                                  fwd_hit,
    output logic [0:odd_pipe_pkg::QUAD_WIDTH-1]   fwd_value,
    output logic                                  wb_valid,
    output logic [0:odd_pipe_pkg::ADDR_WIDTH-1]   wb_addr,
    output logic [0:odd_pipe_pkg::QUAD_WIDTH-1]   wb_value
);

    import odd_pipe_pkg::*;

    fw_entry_t last;

    assign fwd_hit = |stage_hit;

    // walk from the oldest stage so the youngest hit is assigned last
    always_comb
    begin
        fwd_value = '0;
        for (int j = PIPE_DEPTH - 1; j >= 0; j--)
        begin
            if (stage_hit[j])
                fwd_value = stage_entry[j].value;
        end
    end

    // writeback leaves from stage 7
    assign last     = stage_entry[PIPE_DEPTH-1];
    assign wb_valid = last.valid && last.write_en;
    assign wb_addr  = last.rt_addr;
    assign wb_value = last.value;

endmodule

/* verilog/odd_pipe.sv */
`timescale 1ns/100ps

module odd_pipe (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  issue_valid,
    input  odd_pipe_pkg::issue_t                  issue,
    input  logic [0:odd_pipe_pkg::ADDR_WIDTH-1]   query_addr,
    output logic                                  branch_taken,
    output logic [0:odd_pipe_pkg::PC_WIDTH-1]     pc_target,
    output logic                                  flush,
    output logic                                  fwd_hit,
    output logic [0:odd_pipe_pkg::QUAD_WIDTH-1]   fwd_value,
    output logic                                  wb_valid,
    output logic [0:odd_pipe_pkg::ADDR_WIDTH-1]   wb_addr,
    output logic [0:odd_pipe_pkg::QUAD_WIDTH-1]   wb_value
);

    import odd_pipe_pkg::*;

    issue_t                latched;
    logic                  latched_valid;
    fw_entry_t             stage_in    [PIPE_DEPTH];
    fw_entry_t             stage_entry [PIPE_DEPTH];
    logic [PIPE_DEPTH-1:0] stage_hit;

    // a taken branch kills the instruction right behind it
    assign flush = branch_taken;

    operand_latch operand_latch_inst (
        .clock         (clock),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .flush         (flush),
        .latched       (latched),
        .latched_valid (latched_valid)
    );

    execute_stage execute_stage_inst (
        .latched       (latched),
        .latched_valid (latched_valid),
        .entry         (stage_in[0]),
        .branch_taken  (branch_taken),
        .pc_target     (pc_target)
    );

    for (genvar j = 0; j < PIPE_DEPTH; j++)
    begin : g_stage
        if (j < PIPE_DEPTH - 1)
        begin : g_link
            assign stage_in[j+1] = stage_entry[j];
        end

        forward_stage #(.STAGE(j + 1)) forward_stage_inst (
            .clock      (clock),
            .reset      (reset),
            .entry_in   (stage_in[j]),
            .entry_out  (stage_entry[j]),
            .query_addr (query_addr),
            .hit        (stage_hit[j])
        );
    end

    forward_select forward_select_inst (
        .stage_entry (stage_entry),
        .stage_hit   (stage_hit),
        .fwd_hit     (fwd_hit),
        .fwd_value   (fwd_value),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_value    (wb_value)
    );

endmodule

/* tb/odd_pipe_chk.sv */
`timescale 1ns/100ps

module odd_pipe_chk (
    input logic                                clock,
    input logic                                reset,
    input logic                                branch_taken,
    input logic [0:odd_pipe_pkg::PC_WIDTH-1]   pc_target,
    input logic                                wb_valid,
    input logic                                fwd_hit
);

    logic reset_d;
    int   assert_failures = 0;

    always_ff @(posedge clock)
        reset_d <= reset;

    // a taken branch flushes its successor, so never two in a row
    taken_once: assert property (@(posedge clock) disable iff (reset)
        branch_taken |=> !branch_taken)
        else
        begin
            assert_failures++;
            $error("branch_taken high in two consecutive cycles");
        end

    taken_aligned: assert property (@(posedge clock) disable iff (reset)
        branch_taken |-> pc_target[30:31] == 2'b00)
        else
        begin
            assert_failures++;
            $error("pc_target not word aligned on a taken branch");
        end

    // first edge of reset still sees the power-up state
    reset_quiet: assert property (@(posedge clock)
        reset && reset_d |-> !wb_valid && !fwd_hit && !branch_taken)
        else
        begin
            assert_failures++;
            $error("pipe outputs active during reset");
        end

endmodule

/* tb/odd_pipe_tb.sv */
`timescale 1ns/100ps

module odd_pipe_tb;

    import odd_pipe_pkg::*;

    logic                  clock;
    logic                  reset;
    logic                  issue_valid;
    issue_t                issue;
    logic [0:ADDR_WIDTH-1] query_addr;
    logic                  branch_taken;
    logic [0:PC_WIDTH-1]   pc_target;
    logic                  flush;
    logic                  fwd_hit;
    logic [0:QUAD_WIDTH-1] fwd_value;
    logic                  wb_valid;
    logic [0:ADDR_WIDTH-1] wb_addr;
    logic [0:QUAD_WIDTH-1] wb_value;

    int          cycle;
    int          checks;
    int          mismatches;
    int          missing;
    logic [31:0] lfsr_state;

    odd_pipe odd_pipe_inst (.*);

    bind odd_pipe odd_pipe_chk odd_pipe_chk_inst (.*);

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock)
        cycle <= cycle + 1;

    initial
    begin
        #100000;
        $display("timeout: the test sequence did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

    // galois lfsr, stepped once per bit, bits collect at the right end
    function automatic logic [0:QUAD_WIDTH-1] random_bits(input int width);
        logic [0:QUAD_WIDTH-1] value;
        logic                  bit_out;
        value = '0;
        for (int k = 0; k < width; k++)
        begin
            bit_out    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (bit_out)
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            value = {value[1:QUAD_WIDTH-1], bit_out};
        end
        return value;
    endfunction

    // expected result of one instruction
    function automatic void predict(input issue_t ins, output logic writes,
                                    output logic [0:QUAD_WIDTH-1] value,
                                    output logic [3:0] latency, output logic taken,
                                    output logic [0:PC_WIDTH-1] target);
        int          amount;
        int          width;
        logic        rotate;
        logic [31:0] offset;
        logic [31:0] gathered;
        writes  = 1'b0;
        value   = '0;
        latency = 4'd4;
        amount  = -1;
        width   = 0;
        rotate  = ins.op inside {OP_ROTQBI, OP_ROTQBII, OP_ROTQBY, OP_ROTQBYI};
        offset  = {{14{ins.i16[15]}}, ins.i16, 2'b00};
        target  = ins.op inside {OP_BRA, OP_BRASL} ? offset : ins.pc + offset;
        case (ins.op)
            OP_SHLQBI, OP_ROTQBI:   amount = ins.rb[29:31];
            OP_SHLQBII, OP_ROTQBII: amount = ins.i7[2:0];
            OP_SHLQBY:  amount = 8 * ins.rb[27:31];
            OP_SHLQBYI: amount = 8 * ins.i7[4:0];
            OP_ROTQBY:  amount = 8 * ins.rb[28:31];
            OP_ROTQBYI: amount = 8 * ins.i7[3:0];
            OP_GBB:     width = 8;
            OP_GBH:     width = 16;
            OP_GB:      width = 32;
            default:    ;
        endcase
        case (ins.op)
            OP_BR, OP_BRA, OP_BRSL, OP_BRASL: taken = 1'b1;
            OP_BRNZ:  taken = (ins.rb[0:31] != 0);
            OP_BRZ:   taken = (ins.rb[0:31] == 0);
            OP_BRHNZ: taken = (ins.rb[16:31] != 0);
            OP_BRHZ:  taken = (ins.rb[16:31] == 0);
            default:  taken = 1'b0;
        endcase
        // bit i of the result comes from bit i+amount of ra
        if (amount >= 0)
        begin
            writes = 1'b1;
            for (int i = 0; i < QUAD_WIDTH; i++)
            begin
                if (i + amount < QUAD_WIDTH)
                    value[i] = ins.ra[i + amount];
                else if (rotate)
                    value[i] = ins.ra[i + amount - QUAD_WIDTH];
            end
        end
        if (width > 0)
        begin
            writes   = 1'b1;
            gathered = '0;
            for (int e = 0; e < QUAD_WIDTH / width; e++)
                gathered = {gathered[30:0], ins.ra[e*width + width - 1]};
            value = {gathered, 96'd0};
        end
        if (ins.op inside {OP_BRSL, OP_BRASL})
        begin
            writes  = 1'b1;
            latency = 4'd1;
            value   = {ins.pc + 32'd4, 96'd0};
        end
    endfunction

    task automatic report_mismatch(input string what);
        mismatches++;
        $display("mismatch at %0t: %s", $time, what);
    endtask

    // permute that trails another instruction by one cycle
    function automatic issue_t follower(input logic [0:ADDR_WIDTH-1] rt);
        issue_t ins;
        ins         = '0;
        ins.op      = OP_SHLQBII;
        ins.ra      = random_bits(QUAD_WIDTH);
        ins.i7      = 7'd3;
        ins.rt_addr = rt;
        return ins;
    endfunction

    // strobe first in cycle c, second in c+1, and check every output up to c+12
    task automatic run_pair(input issue_t first, input issue_t second, input logic send_second);
        logic                  w1;
        logic                  w2;
        logic                  t1;
        logic                  t2;
        logic [0:QUAD_WIDTH-1] v1;
        logic [0:QUAD_WIDTH-1] v2;
        logic [3:0]            l1;
        logic [3:0]            l2;
        logic [0:PC_WIDTH-1]   tg1;
        logic [0:PC_WIDTH-1]   tg2;
        logic                  exp_taken;
        logic [0:PC_WIDTH-1]   exp_target;
        logic                  exp_wb;
        logic [0:ADDR_WIDTH-1] exp_addr;
        logic [0:QUAD_WIDTH-1] exp_val;
        logic                  hit1;
        logic                  hit2;
        int                    c;
        int                    seen;
        predict(first, w1, v1, l1, t1, tg1);
        predict(second, w2, v2, l2, t2, tg2);
        // the second one is lost behind a taken branch
        if (!send_second || t1)
        begin
            w2 = 1'b0;
            t2 = 1'b0;
        end
        seen = 0;
        @(posedge clock);
        #1;
        issue       = first;
        issue_valid = 1'b1;
        query_addr  = first.rt_addr;
        c           = cycle;
        for (int t = c + 1; t <= c + 12; t++)
        begin
            @(posedge clock);
            #1;
            issue       = second;
            issue_valid = send_second && (t == c + 1);
            @(negedge clock);
            checks++;
            exp_taken  = (t == c + 1 && t1) || (t == c + 2 && t2);
            exp_target = (t == c + 1) ? tg1 : tg2;
            if (flush !== exp_taken)
                report_mismatch($sformatf("flush %b in c+%0d", flush, t - c));
            if (branch_taken !== exp_taken)
                report_mismatch($sformatf("branch_taken %b in c+%0d", branch_taken, t - c));
            else if (branch_taken === 1'b1 && pc_target !== exp_target)
                report_mismatch($sformatf("pc_target %h, expected %h", pc_target, exp_target));
            exp_wb   = (t == c + 8 && w1) || (t == c + 9 && w2);
            exp_addr = (t == c + 8) ? first.rt_addr : second.rt_addr;
            exp_val  = (t == c + 8) ? v1 : v2;
            if (wb_valid === 1'b1)
                seen++;
            if (wb_valid !== exp_wb)
                report_mismatch($sformatf("wb_valid %b in c+%0d", wb_valid, t - c));
            else if (exp_wb && (wb_addr !== exp_addr || wb_value !== exp_val))
                report_mismatch($sformatf("writeback %h to %0d, expected %h to %0d",
                                          wb_value, wb_addr, exp_val, exp_addr));
            // stage j holds an entry strobed in cycle s during cycle s+1+j
            hit1 = w1 && (t - c - 1) >= int'(l1) && (t - c - 1) <= PIPE_DEPTH;
            hit2 = w2 && second.rt_addr == query_addr
                   && (t - c - 2) >= int'(l2) && (t - c - 2) <= PIPE_DEPTH;
            if (fwd_hit !== (hit1 || hit2))
                report_mismatch($sformatf("fwd_hit %b in c+%0d", fwd_hit, t - c));
            else if (fwd_hit === 1'b1 && fwd_value !== (hit2 ? v2 : v1))
                report_mismatch($sformatf("fwd_value %h in c+%0d", fwd_value, t - c));
        end
        if (seen < int'(w1) + int'(w2))
        begin
            missing++;
            $display("expected writeback did not arrive within 12 cycles at %0t", $time);
        end
    endtask

    task automatic test_idle();
        for (int k = 0; k < 10; k++)
        begin
            @(negedge clock);
            checks++;
            if (branch_taken !== 1'b0 || flush !== 1'b0 || wb_valid !== 1'b0
                || fwd_hit !== 1'b0)
                report_mismatch("pipe outputs not idle after reset");
        end
    endtask

    task automatic test_shift_rotate();
        opcode_t ops [8] = '{OP_SHLQBI, OP_SHLQBII, OP_SHLQBY, OP_SHLQBYI,
                             OP_ROTQBI, OP_ROTQBII, OP_ROTQBY, OP_ROTQBYI};
        int      counts [7] = '{0, 1, 7, 15, 16, 17, 31};
        issue_t  ins;
        foreach (ops[k])
        begin
            foreach (counts[n])
            begin
                ins           = '0;
                ins.op        = ops[k];
                ins.ra        = random_bits(QUAD_WIDTH);
                ins.rb        = random_bits(QUAD_WIDTH);
                ins.rb[27:31] = counts[n][4:0];
                // upper i7 bits set to show they are ignored
                ins.i7        = {2'b11, counts[n][4:0]};
                ins.rt_addr   = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
                run_pair(ins, follower('0), 1'b0);
            end
        end
    endtask

    task automatic test_gather();
        opcode_t ops [3] = '{OP_GBB, OP_GBH, OP_GB};
        issue_t  ins;
        foreach (ops[k])
        begin
            for (int r = 0; r < 3; r++)
            begin
                ins         = '0;
                ins.op      = ops[k];
                ins.ra      = (r == 0) ? {QUAD_WIDTH{1'b1}} : random_bits(QUAD_WIDTH);
                ins.rt_addr = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
                run_pair(ins, follower('0), 1'b0);
            end
        end
    endtask

    // every branch form, followed one cycle later by a permute or a link branch
    task automatic test_branches();
        opcode_t ops [8] = '{OP_BR, OP_BRA, OP_BRSL, OP_BRASL,
                             OP_BRNZ, OP_BRZ, OP_BRHNZ, OP_BRHZ};
        issue_t  ins;
        issue_t  trailer;
        foreach (ops[k])
        begin
            for (int r = 0; r < 4; r++)
            begin
                ins    = '0;
                ins.op = ops[k];
                ins.rb = random_bits(QUAD_WIDTH);
                // zero word, zero halfword only, small nonzero word, random
                case (r)
                    0:       ins.rb[0:31] = '0;
                    1:       ins.rb[0:31] = 32'h0040_0000;
                    2:       ins.rb[0:31] = 32'h0000_0001;
                    default: ;
                endcase
                ins.rt_addr = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
                ins.i16     = 16'(random_bits(16));
                ins.pc      = {30'(random_bits(30)), 2'b00};
                trailer     = follower(ins.rt_addr + 7'd1);
                // a branch right behind a branch, taken only if the first falls through
                if (r == 3)
                begin
                    trailer.op  = OP_BRSL;
                    trailer.pc  = ins.pc + 32'd4;
                    trailer.i16 = 16'(random_bits(16));
                end
                run_pair(ins, trailer, 1'b1);
            end
        end
    endtask

    // two writes to one address, the younger takes over once it is ready
    task automatic test_forwarding();
        issue_t ins;
        for (int r = 0; r < 3; r++)
        begin
            ins         = '0;
            ins.op      = OP_ROTQBYI;
            ins.ra      = random_bits(QUAD_WIDTH);
            ins.i7      = 7'(random_bits(7));
            ins.rt_addr = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
            run_pair(ins, follower(ins.rt_addr), 1'b1);
        end
    endtask

    initial
    begin
        lfsr_state  = 32'hfe49_2f50;
        checks      = 0;
        mismatches  = 0;
        missing     = 0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        query_addr  = '0;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        test_idle();
        test_shift_rotate();
        test_gather();
        test_branches();
        test_forwarding();
        $display("checks %0d, mismatches %0d, missing writebacks %0d, assertion failures %0d",
                 checks, mismatches, missing, odd_pipe_inst.odd_pipe_chk_inst.assert_failures);
        if (mismatches == 0 && missing == 0
            && odd_pipe_inst.odd_pipe_chk_inst.assert_failures == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* sim.f */
verilog/odd_pipe_pkg.sv
verilog/operand_latch.sv
verilog/permute_unit.sv
verilog/branch_unit.sv
verilog/execute_stage.sv
verilog/forward_stage.sv
verilog/forward_select.sv
verilog/odd_pipe.sv
tb/odd_pipe_chk.sv
tb/odd_pipe_tb.sv

/* Bender.yml */
package:
  name: odd_pipe

sources:
  - files:
      - verilog/odd_pipe_pkg.sv
      - verilog/operand_latch.sv
      - verilog/permute_unit.sv
      - verilog/branch_unit.sv
      - verilog/execute_stage.sv
      - verilog/forward_stage.sv
      - verilog/forward_select.sv
      - verilog/odd_pipe.sv
  - target: simulation
    files:
      - tb/odd_pipe_chk.sv
      - tb/odd_pipe_tb.sv
